//--- src.f
+incdir+.
mips_pkg.sv
register_file.sv
decode_control.sv
operand_forward.sv
alu_execute.sv
mips_core_top.sv
tb_mips_core.sv

//--- run.sh
#!/bin/sh
verilator --binary --assert --top-module tb_mips_core -f src.f -Mdir obj_dir || exit 1
out=$(./obj_dir/Vtb_mips_core 2>&1)
echo "$out"
echo "$out" | grep -qF "All tests passed!" && exit 0 || exit 1

//--- tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: name, instruction word, then expected write_enable,
// write_address, write_data, illegal, overflow (registers start at zero)
task automatic load_vectors();
    // logic and immediate forms
    add_vector("lui r1,0x1234", 32'h3c011234, 1'b1, 5'd1, 32'h12340000, 1'b0, 1'b0);
    add_vector("ori r1,r1,0x5678", 32'h34215678, 1'b1, 5'd1, 32'h12345678, 1'b0, 1'b0);
    add_vector("lui r2,0xf0f0", 32'h3c02f0f0, 1'b1, 5'd2, 32'hf0f00000, 1'b0, 1'b0);
    add_vector("ori r2,r2,0xff00", 32'h3442ff00, 1'b1, 5'd2, 32'hf0f0ff00, 1'b0, 1'b0);
    add_vector("and r3,r1,r2", 32'h00221824, 1'b1, 5'd3, 32'h10305600, 1'b0, 1'b0);
    add_vector("or r4,r1,r2", 32'h00222025, 1'b1, 5'd4, 32'hf2f4ff78, 1'b0, 1'b0);
    add_vector("xor r5,r1,r2", 32'h00222826, 1'b1, 5'd5, 32'he2c4a978, 1'b0, 1'b0);
    add_vector("nor r6,r1,r2", 32'h00223027, 1'b1, 5'd6, 32'h0d0b0087, 1'b0, 1'b0);
    // zero-extended immediates
    add_vector("andi r7,r2,0x8f0f", 32'h30478f0f, 1'b1, 5'd7, 32'h00008f00, 1'b0, 1'b0);
    add_vector("xori r8,r1,0xffff", 32'h3828ffff, 1'b1, 5'd8, 32'h1234a987, 1'b0, 1'b0);

    // shifts
    add_vector("sll r9,r1,4", 32'h00014900, 1'b1, 5'd9, 32'h23456780, 1'b0, 1'b0);
    add_vector("srl r10,r2,8", 32'h00025202, 1'b1, 5'd10, 32'h00f0f0ff, 1'b0, 1'b0);
    add_vector("sra r11,r2,8", 32'h00025a03, 1'b1, 5'd11, 32'hfff0f0ff, 1'b0, 1'b0);
    add_vector("addiu r12,r0,36", 32'h240c0024, 1'b1, 5'd12, 32'h00000024, 1'b0, 1'b0);
    // amount is 36 mod 32
    add_vector("sllv r13,r1,r12", 32'h01816804, 1'b1, 5'd13, 32'h23456780, 1'b0, 1'b0);
    add_vector("srlv r14,r2,r12", 32'h01827006, 1'b1, 5'd14, 32'h0f0f0ff0, 1'b0, 1'b0);
    add_vector("srav r15,r2,r12", 32'h01827807, 1'b1, 5'd15, 32'hff0f0ff0, 1'b0, 1'b0);

    // arithmetic and compares
    add_vector("addi r16,r0,-5", 32'h2010fffb, 1'b1, 5'd16, 32'hfffffffb, 1'b0, 1'b0);
    add_vector("slt r17,r16,r12", 32'h020c882a, 1'b1, 5'd17, 32'h00000001, 1'b0, 1'b0);
    add_vector("sltu r18,r16,r12", 32'h020c902b, 1'b1, 5'd18, 32'h00000000, 1'b0, 1'b0);
    add_vector("slti r19,r16,-4", 32'h2a13fffc, 1'b1, 5'd19, 32'h00000001, 1'b0, 1'b0);
    add_vector("sltiu r20,r12,-1", 32'h2d94ffff, 1'b1, 5'd20, 32'h00000001, 1'b0, 1'b0);
    add_vector("lui r21,0x7fff", 32'h3c157fff, 1'b1, 5'd21, 32'h7fff0000, 1'b0, 1'b0);
    add_vector("ori r21,r21,0xffff", 32'h36b5ffff, 1'b1, 5'd21, 32'h7fffffff, 1'b0, 1'b0);
    add_vector("add r22,r21,r20 ovf", 32'h02b4b020, 1'b0, 5'd22, 32'h80000000, 1'b0, 1'b1);
    add_vector("addu r23,r21,r20", 32'h02b4b821, 1'b1, 5'd23, 32'h80000000, 1'b0, 1'b0);
    add_vector("sub r24,r23,r20 ovf", 32'h02f4c022, 1'b0, 5'd24, 32'h7fffffff, 1'b0, 1'b1);
    add_vector("subu r24,r12,r16", 32'h0190c023, 1'b1, 5'd24, 32'h00000029, 1'b0, 1'b0);

    // conditional moves
    add_vector("movn r25,r1,r17", 32'h0031c80b, 1'b1, 5'd25, 32'h12345678, 1'b0, 1'b0);
    add_vector("movn r26,r1,r18", 32'h0032d00b, 1'b0, 5'd26, 32'h12345678, 1'b0, 1'b0);
    add_vector("movz r26,r4,r18", 32'h0092d00a, 1'b1, 5'd26, 32'hf2f4ff78, 1'b0, 1'b0);
    add_vector("movz r27,r4,r17", 32'h0091d80a, 1'b0, 5'd27, 32'hf2f4ff78, 1'b0, 1'b0);

    // unknown words and the zero register
    add_vector("opcode 0x3f", 32'hfc000000, 1'b0, 5'd0, 32'h00000000, 1'b1, 1'b0);
    add_vector("mfhi r1", 32'h00000810, 1'b0, 5'd0, 32'h00000000, 1'b1, 1'b0);
    add_vector("add r0,r1,r2", 32'h00220020, 1'b0, 5'd0, 32'h03255578, 1'b0, 1'b0);

    // producers one and two ahead
    add_vector("addiu r28,r0,100", 32'h241c0064, 1'b1, 5'd28, 32'h00000064, 1'b0, 1'b0);
    add_vector("addiu r29,r0,7", 32'h241d0007, 1'b1, 5'd29, 32'h00000007, 1'b0, 1'b0);
    add_vector("subu r30,r28,r29", 32'h039df023, 1'b1, 5'd30, 32'h0000005d, 1'b0, 1'b0);
    add_vector("xor r31,r30,r28", 32'h03dcf826, 1'b1, 5'd31, 32'h00000039, 1'b0, 1'b0);
endtask

`endif

//--- tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        instr_valid;
    mips_instr_u instr;
    logic        instr_ready;
    logic        result_valid;
    wb_result_t  result;
    logic        result_ready;

    string      names[$];
    word_t      words[$];
    wb_result_t expected[$];

    int cycle_count = 0;
    int cycle_limit = 0;

    mips_core_top uut (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

    always #10 clk = ~clk;

    task automatic add_vector(input string name, input word_t word, input logic we,
                              input reg_addr_t addr, input word_t data, input logic ill,
                              input logic ovf);
        wb_result_t exp;
        exp.write_enable = we;
        exp.write_address = addr;
        exp.write_data = data;
        exp.illegal = ill;
        exp.overflow = ovf;
        exp.spare = 1'b0;
        names.push_back(name);
        words.push_back(word);
        expected.push_back(exp);
    endtask

    `include "tb_vectors.svh"

    task automatic report_mismatch(input string name, input wb_result_t exp,
                                   input wb_result_t act);
        $write("FAIL %s: expected we=%b addr=%0d data=%h ill=%b ovf=%b", name,
               exp.write_enable, exp.write_address, exp.write_data, exp.illegal,
               exp.overflow);
        $display(", actual we=%b addr=%0d data=%h ill=%b ovf=%b", act.write_enable,
                 act.write_address, act.write_data, act.illegal, act.overflow);
    endtask

    // ----------------------------------------
    // timeout
    // ----------------------------------------
    always @(posedge clk) begin
        if (!reset) begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("Timeout: results stopped arriving after %0d cycles", cycle_count);
                $display("Test failures found");
                $fatal(1);
            end
        end
    end

    // ----------------------------------------
    // driver and checker
    // ----------------------------------------
    initial begin
        int         sent;
        int         checked;
        logic       in_fire;
        logic       out_fire;
        logic       stalled;
        wb_result_t seen;

        sent = 0;
        checked = 0;
        in_fire = 1'b0;
        out_fire = 1'b0;
        stalled = 1'b0;
        seen = '0;
        clk = 1'b0;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        result_ready = 1'b0;
        void'($urandom(32'h8cce));
        load_vectors();
        cycle_limit = 20 * names.size() + 100;

        repeat (10) @(negedge clk);
        reset = 1'b0;
        #5;
        assert (!result_valid && instr_ready) else begin
            $display("Pipeline was not empty and ready after reset");
            $display("Test failures found");
            $fatal(1);
        end

        while (checked < names.size()) begin
            @(negedge clk);
            // transfers of the rising edge just passed
            if (in_fire) begin
                sent++;
            end
            if (out_fire) begin
                assert (seen == expected[checked]) else begin
                    report_mismatch(names[checked], expected[checked], seen);
                    $display("Test failures found");
                    $fatal(1);
                end
                checked++;
            end
            // an offered word stays put until taken
            if (!instr_valid || in_fire) begin
                if (sent < names.size() && $urandom % 4 != 0) begin
                    instr_valid = 1'b1;
                    instr = words[sent];
                end else begin
                    instr_valid = 1'b0;
                end
            end
            result_ready = ($urandom % 2) == 1;
            #5;
            assert (!stalled || (result_valid && result == seen)) else begin
                $display("Result changed or was dropped while result_ready was low");
                $display("Test failures found");
                $fatal(1);
            end
            in_fire = instr_valid && instr_ready;
            out_fire = result_valid && result_ready;
            stalled = result_valid && !result_ready;
            seen = result;
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- mips_core_top.sv
`timescale 1ns/1ps

module mips_core_top import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  mips_instr_u instr,
    output logic        instr_ready,
    output logic        result_valid,
    output wb_result_t  result,
    input  logic        result_ready
);

    logic         advance;
    logic         ex_valid;
    logic         write_strobe;
    id_ctrl_t     ex_ctrl;
    logic         b_is_imm;
    logic         a_is_shamt;
    word_t        imm_ext;
    reg_addr_t    rs_addr;
    reg_addr_t    rt_addr;
    word_t        rs_data;
    word_t        rt_data;
    ex_operands_t ex_operands;
    wb_result_t   ex_result;

    decode_control u_decode_control (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_ready (result_ready),
        .instr_ready  (instr_ready),
        .result_valid (result_valid),
        .advance      (advance),
        .ex_valid     (ex_valid),
        .write_strobe (write_strobe),
        .ex_ctrl      (ex_ctrl),
        .b_is_imm     (b_is_imm),
        .a_is_shamt   (a_is_shamt),
        .imm_ext      (imm_ext),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr)
    );

    register_file u_register_file (
        .clk          (clk),
        .reset        (reset),
        .write_strobe (write_strobe),
        .write_result (result),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .rs_data      (rs_data),
        .rt_data      (rt_data)
    );

    operand_forward u_operand_forward (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .imm_ext     (imm_ext),
        .b_is_imm    (b_is_imm),
        .a_is_shamt  (a_is_shamt),
        .ex_result   (ex_result),
        .ex_valid    (ex_valid),
        .wb_result   (result),
        .wb_valid    (result_valid),
        .ex_operands (ex_operands)
    );

    alu_execute u_alu_execute (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .ex_valid    (ex_valid),
        .ex_ctrl     (ex_ctrl),
        .ex_operands (ex_operands),
        .ex_result   (ex_result),
        .result      (result)
    );

endmodule

//--- alu_execute.sv
`timescale 1ns/1ps

module alu_execute import mips_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         advance,
    input  logic         ex_valid,
    input  id_ctrl_t     ex_ctrl,
    input  ex_operands_t ex_operands,
    output wb_result_t   ex_result,
    output wb_result_t   result
);

    word_t a;
    word_t b;
    word_t sum;
    word_t diff;
    word_t data;
    logic  overflow;
    logic  write_enable;

    assign a = ex_operands.operand_a;
    assign b = ex_operands.operand_b;
    assign sum = a + b;
    assign diff = a - b;

    // ----------------------------------------
    // execute
    // ----------------------------------------
    // shifts always move operand_b by operand_a[4:0]
    always_comb begin
        data = '0;
        overflow = 1'b0;
        write_enable = ex_ctrl.write_enable;
        case (ex_ctrl.alu_op)
            op_or:   data = a | b;
            op_and:  data = a & b;
            op_xor:  data = a ^ b;
            op_nor:  data = ~(a | b);
            op_sll:  data = b << a[4:0];
            op_srl:  data = b >> a[4:0];
            op_sra:  data = word_t'($signed(b) >>> a[4:0]);
            op_addu: data = sum;
            op_subu: data = diff;
            op_slt:  data = {31'b0, $signed(a) < $signed(b)};
            op_sltu: data = {31'b0, a < b};
            op_add: begin
                data = sum;
                overflow = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            op_sub: begin
                data = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            // b holds the rt value here
            op_movn: begin
                data = a;
                write_enable = ex_ctrl.write_enable && (b != '0);
            end
            op_movz: begin
                data = a;
                write_enable = ex_ctrl.write_enable && (b == '0);
            end
            default: write_enable = 1'b0;
        endcase
        if (overflow) begin
            write_enable = 1'b0;
        end
    end

    always_comb begin
        ex_result.write_enable = write_enable && ex_valid;
        ex_result.write_address = ex_ctrl.write_address;
        ex_result.write_data = data;
        ex_result.illegal = ex_ctrl.illegal;
        ex_result.overflow = overflow;
        ex_result.spare = 1'b0;
    end

    // result stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (advance) begin
            result <= ex_result;
        end
    end

endmodule

//--- operand_forward.sv
`timescale 1ns/1ps

module operand_forward import mips_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         advance,
    input  reg_addr_t    rs_addr,
    input  reg_addr_t    rt_addr,
    input  word_t        rs_data,
    input  word_t        rt_data,
    input  word_t        imm_ext,
    input  logic         b_is_imm,
    input  logic         a_is_shamt,
    input  wb_result_t   ex_result,
    input  logic         ex_valid,
    input  wb_result_t   wb_result,
    input  logic         wb_valid,
    output ex_operands_t ex_operands
);

    word_t        rs_fwd;
    word_t        rt_fwd;
    ex_operands_t next_operands;

    // youngest producer wins, then result stage, then register file
    function automatic word_t resolve(input reg_addr_t addr, input word_t rf_data);
        if (ex_valid && ex_result.write_enable && ex_result.write_address == addr) begin
            return ex_result.write_data;
        end else if (wb_valid && wb_result.write_enable &&
                     wb_result.write_address == addr) begin
            return wb_result.write_data;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs_fwd = resolve(rs_addr, rs_data);
        rt_fwd = resolve(rt_addr, rt_data);
        if (a_is_shamt) begin
            next_operands.operand_a = {27'b0, imm_ext[10:6]};
        end else begin
            next_operands.operand_a = rs_fwd;
        end
        next_operands.operand_b = b_is_imm ? imm_ext : rt_fwd;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_operands <= '0;
        end else if (advance) begin
            ex_operands <= next_operands;
        end
    end

endmodule

//--- decode_control.sv
`timescale 1ns/1ps

module decode_control import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  mips_instr_u instr,
    input  logic        result_ready,
    output logic        instr_ready,
    output logic        result_valid,
    output logic        advance,
    output logic        ex_valid,
    output logic        write_strobe,
    output id_ctrl_t    ex_ctrl,
    output logic        b_is_imm,
    output logic        a_is_shamt,
    output word_t       imm_ext,
    output reg_addr_t   rs_addr,
    output reg_addr_t   rt_addr
);

    id_ctrl_t dec;
    logic     is_known;
    word_t    sign_imm;
    word_t    zero_imm;

    assign sign_imm = {{16{instr.i.imm16[15]}}, instr.i.imm16};
    assign zero_imm = {16'h0000, instr.i.imm16};

    // lui reads nothing, so rs is forced to the zero register
    assign rs_addr = (instr.i.opcode == opc_lui) ? '0 : instr.i.rs;
    assign rt_addr = instr.i.rt;

    // ----------------------------------------
    // instruction decode
    // ----------------------------------------
    always_comb begin
        dec = '0;
        dec.alu_op = op_nop;
        is_known = 1'b1;
        imm_ext = zero_imm;
        case (instr.r.opcode)
            opc_special: begin
                case (instr.r.funct)
                    fn_or:   dec.alu_op = op_or;
                    fn_and:  dec.alu_op = op_and;
                    fn_xor:  dec.alu_op = op_xor;
                    fn_nor:  dec.alu_op = op_nor;
                    fn_sllv: dec.alu_op = op_sll;
                    fn_srlv: dec.alu_op = op_srl;
                    fn_srav: dec.alu_op = op_sra;
                    fn_add:  dec.alu_op = op_add;
                    fn_addu: dec.alu_op = op_addu;
                    fn_sub:  dec.alu_op = op_sub;
                    fn_subu: dec.alu_op = op_subu;
                    fn_slt:  dec.alu_op = op_slt;
                    fn_sltu: dec.alu_op = op_sltu;
                    fn_movn: dec.alu_op = op_movn;
                    fn_movz: dec.alu_op = op_movz;
                    // shamt reaches operand_a through imm_ext[10:6]
                    fn_sll: begin
                        dec.alu_op = op_sll;
                        dec.a_is_shamt = 1'b1;
                    end
                    fn_srl: begin
                        dec.alu_op = op_srl;
                        dec.a_is_shamt = 1'b1;
                    end
                    fn_sra: begin
                        dec.alu_op = op_sra;
                        dec.a_is_shamt = 1'b1;
                    end
                    default: is_known = 1'b0;
                endcase
            end
            opc_ori: begin
                dec.alu_op = op_or;
                dec.b_is_imm = 1'b1;
            end
            opc_andi: begin
                dec.alu_op = op_and;
                dec.b_is_imm = 1'b1;
            end
            opc_xori: begin
                dec.alu_op = op_xor;
                dec.b_is_imm = 1'b1;
            end
            opc_lui: begin
                dec.alu_op = op_or;
                dec.b_is_imm = 1'b1;
                imm_ext = {instr.i.imm16, 16'h0000};
            end
            opc_addi: begin
                dec.alu_op = op_add;
                dec.b_is_imm = 1'b1;
                imm_ext = sign_imm;
            end
            opc_addiu: begin
                dec.alu_op = op_addu;
                dec.b_is_imm = 1'b1;
                imm_ext = sign_imm;
            end
            opc_slti: begin
                dec.alu_op = op_slt;
                dec.b_is_imm = 1'b1;
                imm_ext = sign_imm;
            end
            opc_sltiu: begin
                dec.alu_op = op_sltu;
                dec.b_is_imm = 1'b1;
                imm_ext = sign_imm;
            end
            default: is_known = 1'b0;
        endcase

        // rd for R-type, rt for I-type
        if (instr.r.opcode == opc_special) begin
            dec.write_address = instr.r.rd;
        end else begin
            dec.write_address = instr.i.rt;
        end

        if (!is_known) begin
            dec = '0;
            dec.alu_op = op_nop;
            dec.illegal = 1'b1;
        end
        dec.write_enable = is_known && (dec.write_address != '0);
    end

    assign b_is_imm = dec.b_is_imm;
    assign a_is_shamt = dec.a_is_shamt;

    // ----------------------------------------
    // stage valid bits and handshakes
    // ----------------------------------------
    assign advance = !result_valid || result_ready;
    assign instr_ready = advance;
    assign write_strobe = result_valid && result_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
            result_valid <= 1'b0;
            ex_ctrl <= '0;
        end else if (advance) begin
            ex_valid <= instr_valid;
            result_valid <= ex_valid;
            ex_ctrl <= dec;
        end
    end

    // a stalled result is never withdrawn
    assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid);

    // upstream holds an offered word until it is taken
    assert property (@(posedge clk) disable iff (reset)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr));

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file import mips_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       write_strobe,
    input  wb_result_t write_result,
    input  reg_addr_t  rs_addr,
    input  reg_addr_t  rt_addr,
    output word_t      rs_data,
    output word_t      rt_data
);

    word_t regs [32];

    // register zero is never written, so it reads as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_strobe && write_result.write_enable) begin
            regs[write_result.write_address] <= write_result.write_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // decode must never enable a write to $zero
    assert property (@(posedge clk) disable iff (reset)
        write_strobe && write_result.write_enable |-> write_result.write_address != '0);

endmodule

//--- mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // ----------------------------------------
    // opcodes
    // ----------------------------------------
    localparam logic [5:0] opc_special = 6'b000000;
    localparam logic [5:0] opc_addi    = 6'b001000;
    localparam logic [5:0] opc_addiu   = 6'b001001;
    localparam logic [5:0] opc_slti    = 6'b001010;
    localparam logic [5:0] opc_sltiu   = 6'b001011;
    localparam logic [5:0] opc_andi    = 6'b001100;
    localparam logic [5:0] opc_ori     = 6'b001101;
    localparam logic [5:0] opc_xori    = 6'b001110;
    localparam logic [5:0] opc_lui     = 6'b001111;

    // function codes under the special opcode
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_sllv = 6'b000100;
    localparam logic [5:0] fn_srlv = 6'b000110;
    localparam logic [5:0] fn_srav = 6'b000111;
    localparam logic [5:0] fn_movz = 6'b001010;
    localparam logic [5:0] fn_movn = 6'b001011;
    localparam logic [5:0] fn_add  = 6'b100000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_sub  = 6'b100010;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    typedef enum logic [3:0] {
        op_or, op_and, op_xor, op_nor,
        op_sll, op_srl, op_sra,
        op_add, op_addu, op_sub, op_subu, op_slt, op_sltu,
        op_movn, op_movz, op_nop
    } alu_op_e;

    // ----------------------------------------
    // instruction word views
    // ----------------------------------------
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } mips_instr_u;

    // decoded control, decode into execute
    typedef struct packed {
        alu_op_e   alu_op;
        logic      write_enable;
        reg_addr_t write_address;
        logic      illegal;
        logic      b_is_imm;
        logic      a_is_shamt;
    } id_ctrl_t;

    typedef struct packed {
        word_t operand_a;
        word_t operand_b;
    } ex_operands_t;

    typedef struct packed {
        logic      write_enable;
        reg_addr_t write_address;
        word_t     write_data;
        logic      illegal;
        logic      overflow;
        logic      spare;
    } wb_result_t;

endpackage
